//--- rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data and field widths
  ////////////////////////////////////////////////////////////////////////////

  // Operands, results, store data
  typedef logic [31:0] word_t;

  // Register index, x0 hardwired to zero
  typedef logic [4:0] reg_addr_t;

  // funct3 style operation or branch condition
  typedef logic [2:0] alu_sel_t;

  // Load width and sign, consumed in MEM
  typedef logic [2:0] load_ctrl_t;

  // Store width, consumed in MEM
  typedef logic [1:0] store_ctrl_t;

  ////////////////////////////////////////////////////////////////////////////
  // ALU operation encodings (funct3)
  ////////////////////////////////////////////////////////////////////////////

  localparam alu_sel_t ALU_ADD  = 3'b000;  // sub when alu_alt
  localparam alu_sel_t ALU_SLL  = 3'b001;
  localparam alu_sel_t ALU_SLT  = 3'b010;
  localparam alu_sel_t ALU_SLTU = 3'b011;
  localparam alu_sel_t ALU_XOR  = 3'b100;
  localparam alu_sel_t ALU_SRL  = 3'b101;  // sra when alu_alt
  localparam alu_sel_t ALU_OR   = 3'b110;
  localparam alu_sel_t ALU_AND  = 3'b111;

  // Branch conditions, same field when compare is set
  localparam alu_sel_t CMP_EQ  = 3'b000;
  localparam alu_sel_t CMP_NE  = 3'b001;
  localparam alu_sel_t CMP_LT  = 3'b100;
  localparam alu_sel_t CMP_GE  = 3'b101;
  localparam alu_sel_t CMP_LTU = 3'b110;
  localparam alu_sel_t CMP_GEU = 3'b111;

endpackage

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu import exec_pkg::*; #(
  parameter int PC_WIDTH = 16
) (
  input  word_t                a,
  input  word_t                b,
  input  logic [PC_WIDTH-1:0]  pc,
  input  alu_sel_t             alu_sel,
  input  logic                 alu_alt,
  input  logic                 compare,
  input  logic                 lui,
  input  logic                 jal,
  input  logic                 jalr,
  output word_t                result,
  output logic                 comp_res
);

  ////////////////////////////////////////////////////////////////////////////
  // Shared arithmetic
  ////////////////////////////////////////////////////////////////////////////

  // Subtraction also feeds the compare path
  word_t               sum;
  word_t               diff;
  logic [4:0]          shamt;
  logic                lt_signed;
  logic                lt_unsigned;
  logic                equal;
  logic [PC_WIDTH-1:0] link;
  word_t               op_res;
  logic                cond;

  assign sum  = a + b;
  assign diff = a - b;

  // Only low five bits of b shift in RV32I
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;
  assign equal       = (a == b);

  // Return address wraps within the PC width
  assign link = pc + PC_WIDTH'(4);

  ////////////////////////////////////////////////////////////////////////////
  // Register and immediate operations
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_sel)
      ALU_ADD:  op_res = alu_alt ? diff : sum;
      ALU_SLL:  op_res = a << shamt;
      ALU_SLT:  op_res = {31'd0, lt_signed};
      ALU_SLTU: op_res = {31'd0, lt_unsigned};
      ALU_XOR:  op_res = a ^ b;
      // Arithmetic right shift keeps the sign
      ALU_SRL:  op_res = alu_alt ? word_t'($signed(a) >>> shamt) : (a >> shamt);
      ALU_OR:   op_res = a | b;
      ALU_AND:  op_res = a & b;
      default:  op_res = sum;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Branch condition
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_sel)
      CMP_EQ:  cond = equal;
      CMP_NE:  cond = !equal;
      CMP_LT:  cond = lt_signed;
      CMP_GE:  cond = !lt_signed;
      CMP_LTU: cond = lt_unsigned;
      CMP_GEU: cond = !lt_unsigned;
      // 010 and 011 are not branches
      default: cond = 1'b0;
    endcase
  end

  assign comp_res = compare & cond;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (lui) begin
      // Immediate already shifted by decode
      result = b;
    end else if (jal || jalr) begin
      result = word_t'(link);
    end else if (compare) begin
      // alu_sel holds a branch code here
      result = diff;
    end else begin
      result = op_res;
    end
  end

endmodule

`default_nettype wire

//--- rtl/operand_forward.sv
`default_nettype none

module operand_forward import exec_pkg::*; (
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  input  word_t     imm,
  input  logic      alusrc,
  // Own EX/MEM register
  input  logic      ex_valid,
  input  reg_addr_t ex_rd,
  input  logic      ex_regwrite,
  input  logic      ex_memread,
  input  word_t     ex_res,
  // Later stages
  input  logic      mem_wb_regwrite,
  input  reg_addr_t mem_wb_rd,
  input  word_t     mem_wb_res,
  input  logic      wb_id_regwrite,
  input  reg_addr_t wb_id_rd,
  input  word_t     wb_id_res,
  output word_t     op_a,
  output word_t     op_b,
  output word_t     store_data,
  output logic      load_use
);

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding priority
  ////////////////////////////////////////////////////////////////////////////

  // EX/MEM result usable only when it is not a pending load
  logic  ex_src_ok;
  word_t fwd_rs1;
  word_t fwd_rs2;

  assign ex_src_ok = ex_valid & ex_regwrite & !ex_memread;

  // Youngest matching producer wins
  function automatic word_t pick_source(
    input reg_addr_t rs,
    input word_t     rf_val
  );
    word_t val;
    if (rs == '0) begin
      // x0 never forwarded
      val = rf_val;
    end else if (ex_src_ok && (ex_rd == rs)) begin
      val = ex_res;
    end else if (mem_wb_regwrite && (mem_wb_rd == rs)) begin
      val = mem_wb_res;
    end else if (wb_id_regwrite && (wb_id_rd == rs)) begin
      val = wb_id_res;
    end else begin
      // Register file copy is current
      val = rf_val;
    end
    return val;
  endfunction

  always_comb begin
    fwd_rs1 = pick_source(rs1, rs1_data);
    fwd_rs2 = pick_source(rs2, rs2_data);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////////////////////

  assign op_a = fwd_rs1;

  // Immediate form replaces rs2 on the B side
  assign op_b = alusrc ? imm : fwd_rs2;

  // Stores always take the register value
  assign store_data = fwd_rs2;

  ////////////////////////////////////////////////////////////////////////////
  // Load-use hazard
  ////////////////////////////////////////////////////////////////////////////

  // Load data only exists after MEM, so wait one cycle
  assign load_use = ex_valid & ex_memread & (ex_rd != '0) &
                    ((ex_rd == rs1) | (ex_rd == rs2));

endmodule

`default_nettype wire

//--- rtl/ex_mem_reg.sv
`default_nettype none

module ex_mem_reg import exec_pkg::*; (
  input  logic        bus,
  input  logic        rst,
  // Input handshake
  input  logic        in_valid,
  input  logic        load_use,
  output logic        in_ready,
  // Output handshake
  input  logic        out_ready,
  output logic        out_valid,
  // Control from decode
  input  reg_addr_t   rd,
  input  logic        regwrite,
  input  logic        memread,
  input  logic        memwrite,
  input  logic        compare,
  input  load_ctrl_t  load_ctrl,
  input  store_ctrl_t store_ctrl,
  // Execute results
  input  word_t       alu_res,
  input  logic        comp_res,
  input  word_t       store_data,
  // EX/MEM register
  output reg_addr_t   ex_mem_rd,
  output logic        ex_mem_regwrite,
  output logic        ex_mem_memread,
  output logic        ex_mem_memwrite,
  output word_t       ex_mem_alu_res,
  output word_t       ex_mem_store_data,
  output logic        ex_mem_comp_res,
  output load_ctrl_t  ex_mem_load_ctrl,
  output store_ctrl_t ex_mem_store_ctrl
);

  ////////////////////////////////////////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////////////////////////////////////////

  logic accept;
  logic wr_en;

  // Room when empty or draining this cycle, never during a load-use stall
  assign in_ready = !load_use && (!out_valid || out_ready);
  assign accept   = in_valid && in_ready;

  // Compare ops write rd only when the condition holds
  assign wr_en = regwrite && (!compare || comp_res);

  ////////////////////////////////////////////////////////////////////////////
  // Register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      out_valid         <= 1'b0;
      ex_mem_rd         <= '0;
      ex_mem_regwrite   <= 1'b0;
      ex_mem_memread    <= 1'b0;
      ex_mem_memwrite   <= 1'b0;
      ex_mem_alu_res    <= '0;
      ex_mem_store_data <= '0;
      ex_mem_comp_res   <= 1'b0;
      ex_mem_load_ctrl  <= '0;
      ex_mem_store_ctrl <= '0;
    end else if (accept) begin
      out_valid         <= 1'b1;
      ex_mem_rd         <= rd;
      ex_mem_regwrite   <= wr_en;
      ex_mem_memread    <= memread;
      ex_mem_memwrite   <= memwrite;
      ex_mem_alu_res    <= alu_res;
      ex_mem_store_data <= store_data;
      ex_mem_comp_res   <= comp_res;
      ex_mem_load_ctrl  <= load_ctrl;
      ex_mem_store_ctrl <= store_ctrl;
    end else if (out_ready) begin
      // Drained with nothing behind it, fields stay as they were
      out_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`default_nettype none

module execute_stage import exec_pkg::*; #(
  parameter int PC_WIDTH = 16
) (
  input  logic                bus,
  input  logic                rst,
  // Decoded instruction
  input  logic                in_valid,
  output logic                in_ready,
  input  logic [PC_WIDTH-1:0] pc,
  input  reg_addr_t           rs1,
  input  reg_addr_t           rs2,
  input  reg_addr_t           rd,
  input  word_t               rs1_data,
  input  word_t               rs2_data,
  input  word_t               imm,
  input  alu_sel_t            alu_sel,
  input  logic                alu_alt,
  input  logic                alusrc,
  input  logic                compare,
  input  logic                lui,
  input  logic                jal,
  input  logic                jalr,
  input  logic                memread,
  input  logic                memwrite,
  input  logic                regwrite,
  input  load_ctrl_t          load_ctrl,
  input  store_ctrl_t         store_ctrl,
  // Feedback from later stages
  input  logic                mem_wb_regwrite,
  input  reg_addr_t           mem_wb_rd,
  input  word_t               mem_wb_res,
  input  logic                wb_id_regwrite,
  input  reg_addr_t           wb_id_rd,
  input  word_t               wb_id_res,
  // EX/MEM side
  output logic                out_valid,
  input  logic                out_ready,
  output reg_addr_t           ex_mem_rd,
  output logic                ex_mem_regwrite,
  output logic                ex_mem_memread,
  output logic                ex_mem_memwrite,
  output word_t               ex_mem_alu_res,
  output word_t               ex_mem_store_data,
  output logic                ex_mem_comp_res,
  output load_ctrl_t          ex_mem_load_ctrl,
  output store_ctrl_t         ex_mem_store_ctrl
);

  ////////////////////////////////////////////////////////////////////////////
  // Operand resolution
  ////////////////////////////////////////////////////////////////////////////

  word_t op_a;
  word_t op_b;
  word_t store_data;
  logic  load_use;
  word_t result;
  logic  comp_res;

  // EX/MEM outputs loop back as the youngest source
  operand_forward u_fwd (
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .imm(imm), .alusrc(alusrc),
    .ex_valid(out_valid), .ex_rd(ex_mem_rd), .ex_regwrite(ex_mem_regwrite),
    .ex_memread(ex_mem_memread), .ex_res(ex_mem_alu_res),
    .mem_wb_regwrite(mem_wb_regwrite), .mem_wb_rd(mem_wb_rd), .mem_wb_res(mem_wb_res),
    .wb_id_regwrite(wb_id_regwrite), .wb_id_rd(wb_id_rd), .wb_id_res(wb_id_res),
    .op_a(op_a), .op_b(op_b), .store_data(store_data), .load_use(load_use)
  );

  ////////////////////////////////////////////////////////////////////////////
  // ALU and pipeline register
  ////////////////////////////////////////////////////////////////////////////

  alu #(.PC_WIDTH(PC_WIDTH)) u_alu (
    .a(op_a), .b(op_b), .pc(pc), .alu_sel(alu_sel), .alu_alt(alu_alt),
    .compare(compare), .lui(lui), .jal(jal), .jalr(jalr),
    .result(result), .comp_res(comp_res)
  );

  ex_mem_reg u_reg (
    .bus(bus), .rst(rst),
    .in_valid(in_valid), .load_use(load_use), .in_ready(in_ready),
    .out_ready(out_ready), .out_valid(out_valid),
    .rd(rd), .regwrite(regwrite), .memread(memread), .memwrite(memwrite),
    .compare(compare), .load_ctrl(load_ctrl), .store_ctrl(store_ctrl),
    .alu_res(result), .comp_res(comp_res), .store_data(store_data),
    .ex_mem_rd(ex_mem_rd), .ex_mem_regwrite(ex_mem_regwrite),
    .ex_mem_memread(ex_mem_memread), .ex_mem_memwrite(ex_mem_memwrite),
    .ex_mem_alu_res(ex_mem_alu_res), .ex_mem_store_data(ex_mem_store_data),
    .ex_mem_comp_res(ex_mem_comp_res), .ex_mem_load_ctrl(ex_mem_load_ctrl),
    .ex_mem_store_ctrl(ex_mem_store_ctrl)
  );

endmodule

`default_nettype wire

//--- bench/execute_stage_properties.sv
`default_nettype none

module execute_stage_properties import exec_pkg::*; (
  input wire logic        bus,
  input wire logic        rst,
  input wire logic        in_ready,
  input wire reg_addr_t   rs1,
  input wire reg_addr_t   rs2,
  input wire logic        out_valid,
  input wire logic        out_ready,
  input wire reg_addr_t   ex_mem_rd,
  input wire logic        ex_mem_regwrite,
  input wire logic        ex_mem_memread,
  input wire logic        ex_mem_memwrite,
  input wire word_t       ex_mem_alu_res,
  input wire word_t       ex_mem_store_data,
  input wire logic        ex_mem_comp_res,
  input wire load_ctrl_t  ex_mem_load_ctrl,
  input wire store_ctrl_t ex_mem_store_ctrl
);

  ////////////////////////////////////////////////////////////////////////////
  // Reset, stall and hazard rules
  ////////////////////////////////////////////////////////////////////////////

  // Register empty and all enables off after reset
  a_reset_clear: assert property (@(posedge bus)
    rst |=> !out_valid && !ex_mem_regwrite && !ex_mem_memread && !ex_mem_memwrite)
    else $error("EX/MEM valid or enables set after reset");

  // Back-pressure freezes the whole register
  a_hold_stalled: assert property (@(posedge bus) disable iff (rst)
    out_valid && !out_ready |=> out_valid
      && $stable(ex_mem_rd) && $stable(ex_mem_regwrite)
      && $stable(ex_mem_memread) && $stable(ex_mem_memwrite)
      && $stable(ex_mem_alu_res) && $stable(ex_mem_store_data)
      && $stable(ex_mem_comp_res) && $stable(ex_mem_load_ctrl)
      && $stable(ex_mem_store_ctrl))
    else $error("EX/MEM output changed while stalled");

  // Pending load feeding either source blocks acceptance
  a_load_use_stall: assert property (@(posedge bus) disable iff (rst)
    out_valid && ex_mem_memread && (ex_mem_rd != '0)
      && ((ex_mem_rd == rs1) || (ex_mem_rd == rs2)) |-> !in_ready)
    else $error("in_ready high during load-use hazard");

endmodule

bind execute_stage execute_stage_properties u_props (
  .bus(bus), .rst(rst), .in_ready(in_ready), .rs1(rs1), .rs2(rs2),
  .out_valid(out_valid), .out_ready(out_ready), .ex_mem_rd(ex_mem_rd),
  .ex_mem_regwrite(ex_mem_regwrite), .ex_mem_memread(ex_mem_memread),
  .ex_mem_memwrite(ex_mem_memwrite), .ex_mem_alu_res(ex_mem_alu_res),
  .ex_mem_store_data(ex_mem_store_data), .ex_mem_comp_res(ex_mem_comp_res),
  .ex_mem_load_ctrl(ex_mem_load_ctrl), .ex_mem_store_ctrl(ex_mem_store_ctrl)
);

`default_nettype wire

//--- bench/execute_stage_tb.sv
`default_nettype none

module execute_stage_tb;
  import exec_pkg::*;

  localparam int    N_INSTR    = 300;
  localparam int    MAX_CYCLES = N_INSTR * 8 + 100;
  // Model memory returns address xor this
  localparam word_t LOAD_KEY   = 32'h5a5a_c3c3;

  logic bus, rst, in_valid, in_ready, out_valid, out_ready;
  logic [15:0] pc;
  reg_addr_t rs1, rs2, rd, mem_wb_rd, wb_id_rd, ex_mem_rd;
  word_t rs1_data, rs2_data, imm, mem_wb_res, wb_id_res, ex_mem_alu_res, ex_mem_store_data;
  alu_sel_t alu_sel;
  logic alu_alt, alusrc, compare, lui, jal, jalr, memread, memwrite, regwrite;
  logic mem_wb_regwrite, wb_id_regwrite;
  logic ex_mem_regwrite, ex_mem_memread, ex_mem_memwrite, ex_mem_comp_res;
  load_ctrl_t load_ctrl, ex_mem_load_ctrl;
  store_ctrl_t store_ctrl, ex_mem_store_ctrl;

  // One expected EX/MEM entry
  typedef struct packed {
    reg_addr_t   rd;
    logic        we;
    logic        mr;
    logic        mw;
    word_t       res;
    word_t       sd;
    logic        cmp;
    load_ctrl_t  lc;
    store_ctrl_t sc;
  } exp_t;

  exp_t exp_q[$];
  word_t arch[32];   // In-order reference state
  word_t rf[32];     // Stale copy written at retirement
  logic mw_we, wi_we;
  reg_addr_t mw_rd, wi_rd, cur_rs1, cur_rs2;
  word_t mw_res, wi_res;
  int seed, issued, retired, errors, timeouts, cycles;

  execute_stage #(.PC_WIDTH(16)) uut (.*);

  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic word_t model_op(input logic [2:0] sel, input logic alt,
                                     input word_t a, input word_t b);
    logic signed [31:0] sa;
    sa = a;
    case (sel)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? word_t'(sa >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] sel, input word_t a, input word_t b);
    case (sel)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic gen_instr();
    logic [31:0] r;
    logic [31:0] c;
    int kind;
    r = $random(seed);
    // First 60 are plain ALU ops on disjoint registers
    kind = (issued < 60) ? 0 : int'(r[2:0]);
    r = $random(seed);
    c = $random(seed);
    if (issued < 60) begin
      cur_rs1 = {1'b0, r[3:0]};
      cur_rs2 = {1'b0, r[7:4]};
      rd <= {1'b1, r[11:8]};
    end else begin
      // Few registers so dependences pile up
      cur_rs1 = {3'b0, r[1:0]};
      cur_rs2 = {3'b0, r[3:2]};
      rd <= {3'b0, r[5:4]};
    end
    rs1 <= cur_rs1;
    rs2 <= cur_rs2;
    imm <= $random(seed);
    pc <= r[31:16];
    alu_sel <= c[2:0];
    alu_alt <= c[4];
    alusrc <= 1'b0;
    {compare, lui, jal, jalr, memread, memwrite, regwrite} <= 7'b0;
    load_ctrl <= c[12:10];
    store_ctrl <= c[14:13];
    case (kind)
      3: {memread, regwrite, alusrc, alu_sel, alu_alt} <= {3'b111, 3'd0, 1'b0};
      4: {memwrite, alusrc, alu_sel, alu_alt} <= {2'b11, 3'd0, 1'b0};
      5: begin
        compare <= 1'b1;
        regwrite <= c[5];
        // 010 and 011 remapped to lt and ge
        alu_sel <= (c[2:1] == 2'b01) ? (c[2:0] ^ 3'b110) : c[2:0];
      end
      6: {lui, alusrc, regwrite} <= 3'b111;
      7: {jal, jalr, alusrc, regwrite} <= {!c[6], c[6], 2'b11};
      default: begin
        regwrite <= 1'b1;
        alusrc <= c[3];
      end
    endcase
    in_valid <= 1'b1;
  endtask

  // Expected EX/MEM entry from in-order execution
  task automatic model_accept();
    exp_t e;
    word_t a;
    word_t b2;
    word_t b;
    logic taken;
    a = arch[rs1];
    b2 = arch[rs2];
    b = alusrc ? imm : b2;
    taken = compare && branch_taken(alu_sel, a, b);
    if (lui) e.res = b;
    else if (jal || jalr) e.res = {16'd0, pc + 16'd4};
    else if (compare) e.res = a - b;
    else e.res = model_op(alu_sel, alu_alt, a, b);
    e.rd = rd;
    e.we = regwrite && (!compare || taken);
    e.mr = memread;
    e.mw = memwrite;
    e.sd = b2;
    e.cmp = taken;
    e.lc = load_ctrl;
    e.sc = store_ctrl;
    exp_q.push_back(e);
    if (e.we && rd != 5'd0) arch[rd] = memread ? (e.res ^ LOAD_KEY) : e.res;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_field(input string name, input word_t got, input word_t want);
    assert (got === want) else begin
      $display("[FAIL] %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_out();
    exp_t e;
    retired++;
    if (exp_q.size() == 0) begin
      $display("Output transfer arrived with no instruction expected");
      errors++;
    end else begin
      e = exp_q.pop_front();
      check_field("ex_mem_rd", 32'(ex_mem_rd), 32'(e.rd));
      check_field("ex_mem_regwrite", 32'(ex_mem_regwrite), 32'(e.we));
      check_field("ex_mem_memread", 32'(ex_mem_memread), 32'(e.mr));
      check_field("ex_mem_memwrite", 32'(ex_mem_memwrite), 32'(e.mw));
      check_field("ex_mem_alu_res", ex_mem_alu_res, e.res);
      // Store data only matters for stores
      if (e.mw) check_field("ex_mem_store_data", ex_mem_store_data, e.sd);
      check_field("ex_mem_comp_res", 32'(ex_mem_comp_res), 32'(e.cmp));
      check_field("ex_mem_load_ctrl", 32'(ex_mem_load_ctrl), 32'(e.lc));
      check_field("ex_mem_store_ctrl", 32'(ex_mem_store_ctrl), 32'(e.sc));
    end
  endtask

  // Downstream model from EX/MEM through MEM/WB and WB/ID to the register file
  always @(posedge bus) begin
    logic [31:0] r;
    if (!rst) begin
      cycles++;
      if (out_valid && out_ready) check_out();
      if (wi_we && wi_rd != 5'd0) rf[wi_rd] = wi_res;
      {wi_we, wi_rd, wi_res} = {mw_we, mw_rd, mw_res};
      mw_we = out_valid && out_ready && ex_mem_regwrite;
      mw_rd = ex_mem_rd;
      mw_res = ex_mem_memread ? (ex_mem_alu_res ^ LOAD_KEY) : ex_mem_alu_res;
      {mem_wb_regwrite, mem_wb_rd, mem_wb_res} <= {mw_we, mw_rd, mw_res};
      {wb_id_regwrite, wb_id_rd, wb_id_res} <= {wi_we, wi_rd, wi_res};
      if (in_valid && in_ready) begin
        model_accept();
        issued++;
        if (issued < N_INSTR) gen_instr();
        else in_valid <= 1'b0;
      end
      // Decode re-reads the register file every cycle
      rs1_data <= rf[cur_rs1];
      rs2_data <= rf[cur_rs2];
      r = $random(seed);
      out_ready <= (issued < 100) ? 1'b1 : (r[1:0] != 2'b00);
    end
  end

  initial begin
    seed = 32'h1e1b_8699;
    {issued, retired, errors, timeouts, cycles} = '0;
    {in_valid, pc, rs1, rs2, rd, rs1_data, rs2_data, imm, alu_sel} = '0;
    {alu_alt, alusrc, compare, lui, jal, jalr, memread, memwrite, regwrite} = '0;
    {load_ctrl, store_ctrl, mem_wb_regwrite, mem_wb_rd, mem_wb_res} = '0;
    {wb_id_regwrite, wb_id_rd, wb_id_res} = '0;
    {mw_we, mw_rd, mw_res, wi_we, wi_rd, wi_res, cur_rs1, cur_rs2} = '0;
    out_ready = 1'b1;
    rst = 1'b1;
    for (int i = 0; i < 32; i++) begin
      arch[i] = (i == 0) ? 32'd0 : $random(seed);
      rf[i] = arch[i];
    end
    repeat (3) @(posedge bus);
    rst <= 1'b0;
    gen_instr();
    // First instruction reads its sources while the downstream model is still in reset
    rs1_data <= rf[cur_rs1];
    rs2_data <= rf[cur_rs2];
    while (retired < N_INSTR && cycles < MAX_CYCLES) @(posedge bus);
    if (retired < N_INSTR) begin
      $display("Timeout after %0d cycles with %0d of %0d retired", cycles, retired, N_INSTR);
      timeouts++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected instructions never left the stage", exp_q.size());
      errors++;
    end
    $display("Summary: %0d mismatches, %0d timeouts, %0d retired", errors, timeouts, retired);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- execute_stage.f
rtl/exec_pkg.sv
rtl/alu.sv
rtl/operand_forward.sv
rtl/ex_mem_reg.sv
rtl/execute_stage.sv
bench/execute_stage_properties.sv
bench/execute_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert --top-module execute_stage_tb \
  -f execute_stage.f -o sim_exec > build.log 2>&1 \
  && ./obj_dir/sim_exec > sim.log 2>&1 \
  || echo "Testbench failed" >> sim.log

cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
